//--- Bender.yml
package:
  name: ooo_core

sources:
  - target: rtl
    files:
      - ooo_pkg.sv
      - rename_table.sv
      - dispatch_stage.sv
      - reservation_station.sv
      - execute_stage.sv
      - ooo_core_top.sv
  - target: test
    files:
      - ooo_core_checker.sv
      - tb_ooo_core.sv

//--- dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  ooo_pkg::rv_inst_u  inst_word,
    output logic               inst_ready,
    input  logic               rs_full,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::rs_entry_t disp_entry
);
    import ooo_pkg::*;

    logic             accept;
    op_t              dec_op;
    logic             dec_ok;
    operand_t         rs1_op;
    operand_t         rs2_op;
    operand_t         src2_sel;
    logic [TAG_W-1:0] next_tag;
    rs_entry_t        disp_q;

    assign inst_ready = ~rs_full;
    assign accept     = inst_valid & inst_ready;

    // Decode opcode and funct fields
    always_comb begin
        dec_op = OP_ADD;
        dec_ok = 1'b0;
        if (inst_word.r_view.opcode == OPC_OP) begin
            unique case ({inst_word.r_view.funct7, inst_word.r_view.funct3})
                {F7_BASE, F3_ADD}:   begin dec_op = OP_ADD; dec_ok = 1'b1; end
                {F7_ALT, F3_ADD}:    begin dec_op = OP_SUB; dec_ok = 1'b1; end
                {F7_BASE, F3_AND}:   begin dec_op = OP_AND; dec_ok = 1'b1; end
                {F7_BASE, F3_OR}:    begin dec_op = OP_OR;  dec_ok = 1'b1; end
                {F7_BASE, F3_XOR}:   begin dec_op = OP_XOR; dec_ok = 1'b1; end
                {F7_BASE, F3_SLT}:   begin dec_op = OP_SLT; dec_ok = 1'b1; end
                {F7_MULDIV, F3_ADD}: begin dec_op = OP_MUL; dec_ok = 1'b1; end
                default:             dec_ok = 1'b0;
            endcase
        end else if ((inst_word.i_view.opcode == OPC_OP_IMM)
                     && (inst_word.i_view.funct3 == F3_ADD)) begin
            dec_op = OP_ADDI;
            dec_ok = 1'b1;
        end
    end

    rename_table u_rename (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (inst_word.r_view.rs1),
        .rs2_addr  (inst_word.r_view.rs2),
        .rs1_op    (rs1_op),
        .rs2_op    (rs2_op),
        .alloc_en  (accept),
        .alloc_rd  (inst_word.r_view.rd),
        .alloc_tag (next_tag),
        .cdb       (cdb)
    );

    // ADDI takes the sign-extended immediate as a ready operand
    always_comb begin
        src2_sel = rs2_op;
        if (dec_op == OP_ADDI) begin
            src2_sel.value = {{(XLEN-12){inst_word.i_view.imm12[11]}}, inst_word.i_view.imm12};
            src2_sel.tag   = '0;
            src2_sel.ready = 1'b1;
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_q.valid <= 1'b0;
            next_tag     <= '0;
        end else begin
            disp_q.valid <= accept;
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_q.op   <= dec_op;
            disp_q.rd   <= inst_word.r_view.rd;
            disp_q.tag  <= next_tag;
            disp_q.src1 <= rs1_op;
            disp_q.src2 <= src2_sel;
        end
    end

    // Wake the held entry too, else a result in this cycle would be missed
    always_comb begin
        disp_entry      = disp_q;
        disp_entry.src1 = wake_operand(disp_q.src1, cdb);
        disp_entry.src2 = wake_operand(disp_q.src2, cdb);
    end

    assert property (@(posedge clk) disable iff (rst) accept |-> dec_ok)
        else $error("dispatch_stage: accepted unsupported instruction %h", inst_word);

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  ooo_pkg::exec_req_t issue_req,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    logic            alu_valid;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_lo;
    // Product stages ahead of the CDB register, which is the last stage
    cdb_t            mul_pipe [MUL_LATENCY-1];

    assign alu_valid = issue_valid && (issue_req.op != OP_MUL);
    // Low word only, upper half is never consumed
    assign mul_lo    = issue_req.opa * issue_req.opb;

    always_comb begin
        unique case (issue_req.op)
            OP_ADD,
            OP_ADDI: alu_result = issue_req.opa + issue_req.opb;
            OP_SUB:  alu_result = issue_req.opa - issue_req.opb;
            OP_AND:  alu_result = issue_req.opa & issue_req.opb;
            OP_OR:   alu_result = issue_req.opa | issue_req.opb;
            OP_XOR:  alu_result = issue_req.opa ^ issue_req.opb;
            OP_SLT:  alu_result = {{(XLEN-1){1'b0}},
                                   $signed(issue_req.opa) < $signed(issue_req.opb)};
            default: alu_result = '0;
        endcase
    end

    // Valid bits of the multiplier pipe and the CDB
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < MUL_LATENCY - 1; k++) begin
                mul_pipe[k].valid <= 1'b0;
            end
            cdb.valid <= 1'b0;
        end else begin
            mul_pipe[0].valid <= issue_valid && (issue_req.op == OP_MUL);
            for (int k = 1; k < MUL_LATENCY - 1; k++) begin
                mul_pipe[k].valid <= mul_pipe[k-1].valid;
            end
            cdb.valid <= mul_pipe[MUL_LATENCY-2].valid || alu_valid;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        mul_pipe[0].tag   <= issue_req.tag;
        mul_pipe[0].rd    <= issue_req.rd;
        mul_pipe[0].value <= mul_lo;
        for (int k = 1; k < MUL_LATENCY - 1; k++) begin
            mul_pipe[k].tag   <= mul_pipe[k-1].tag;
            mul_pipe[k].rd    <= mul_pipe[k-1].rd;
            mul_pipe[k].value <= mul_pipe[k-1].value;
        end
        // Multiplier wins the merge, the station keeps ALU out of its slot
        if (mul_pipe[MUL_LATENCY-2].valid) begin
            cdb.tag   <= mul_pipe[MUL_LATENCY-2].tag;
            cdb.rd    <= mul_pipe[MUL_LATENCY-2].rd;
            cdb.value <= mul_pipe[MUL_LATENCY-2].value;
        end else begin
            cdb.tag   <= issue_req.tag;
            cdb.rd    <= issue_req.rd;
            cdb.value <= alu_result;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !(alu_valid && mul_pipe[MUL_LATENCY-2].valid))
        else $error("execute_stage: ALU and MUL collide on the CDB");

endmodule

//--- filelist.f
ooo_pkg.sv
rename_table.sv
dispatch_stage.sv
reservation_station.sv
execute_stage.sv
ooo_core_top.sv
ooo_core_checker.sv
tb_ooo_core.sv

//--- ooo_core_checker.sv
`timescale 1ns/1ps

module ooo_core_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  ooo_pkg::cdb_t              cdb,
    input  logic                       exp_valid,
    input  logic [ooo_pkg::TAG_W-1:0]  exp_tag,
    input  logic [ooo_pkg::XLEN-1:0]   exp_value,
    input  logic [ooo_pkg::REG_W-1:0]  exp_rd,
    input  int                         exp_name,
    output int                         mismatch_count,
    output int                         missing_count,
    output int                         unexpected_count,
    output int                         outstanding
);
    import ooo_pkg::*;

    // One expectation slot per tag
    logic [XLEN-1:0]     exp_val [2**TAG_W];
    logic [REG_W-1:0]    exp_dst [2**TAG_W];
    int                  exp_id  [2**TAG_W];
    // Tags still waiting for their CDB result
    logic [2**TAG_W-1:0] open_tags;

    assign outstanding = $countones(open_tags);

    always @(posedge clk) begin
        logic [2**TAG_W-1:0] open_n;
        open_n = open_tags;
        if (rst) begin
            open_n           = '0;
            mismatch_count   <= 0;
            missing_count    <= 0;
            unexpected_count <= 0;
        end else begin
            // Result leaving the core
            if (cdb.valid) begin
                if (!open_n[cdb.tag]) begin
                    unexpected_count <= unexpected_count + 1;
                    $display("Unexpected CDB result with tag %0d and value %h at %0t",
                             cdb.tag, cdb.value, $time);
                end else begin
                    if (cdb.value !== exp_val[cdb.tag]) begin
                        mismatch_count <= mismatch_count + 1;
                        $display("Fail test line_%0d: expected %h actual %h",
                                 exp_id[cdb.tag], exp_val[cdb.tag], cdb.value);
                    end else if (cdb.rd !== exp_dst[cdb.tag]) begin
                        mismatch_count <= mismatch_count + 1;
                        $display("Fail test line_%0d: expected rd x%0d actual rd x%0d",
                                 exp_id[cdb.tag], exp_dst[cdb.tag], cdb.rd);
                    end
                    open_n[cdb.tag] = 1'b0;
                end
            end
            // New expectation, the slot must be free by now
            if (exp_valid) begin
                if (open_n[exp_tag]) begin
                    missing_count <= missing_count + 1;
                    $display("Result of test line_%0d never appeared on the CDB",
                             exp_id[exp_tag]);
                end
                open_n[exp_tag]  = 1'b1;
                exp_val[exp_tag] <= exp_value;
                exp_dst[exp_tag] <= exp_rd;
                exp_id[exp_tag]  <= exp_name;
            end
        end
        open_tags <= open_n;
    end

endmodule

//--- ooo_core_stimulus.txt
// Columns: instruction word (hex), expected CDB value (hex)
// Line index is the test name, tag is line index modulo 16
00500093 00000005 // addi x1, x0, 5
FFD00113 FFFFFFFD // addi x2, x0, -3
002081B3 00000002 // add  x3, x1, x2
40208233 00000008 // sub  x4, x1, x2
0020F2B3 00000005 // and  x5, x1, x2
0020E333 FFFFFFFD // or   x6, x1, x2
0020C3B3 FFFFFFF8 // xor  x7, x1, x2
00112433 00000001 // slt  x8, x2, x1
00A40493 0000000B // addi x9, x8, 10
004484B3 00000013 // add  x9, x9, x4
403484B3 00000011 // sub  x9, x9, x3
02948533 00000121 // mul  x10, x9, x9
024505B3 00000908 // mul  x11, x10, x4
06408613 00000069 // addi x12, x1, 100
00C586B3 00000971 // add  x13, x11, x12
04D00013 0000004D // addi x0, x0, 77
00100733 00000005 // add  x14, x0, x1
021087B3 00000019 // mul  x15, x1, x1
023787B3 00000032 // mul  x15, x15, x3
023787B3 00000064 // mul  x15, x15, x3
02178833 000001F4 // mul  x16, x15, x1
023788B3 000000C8 // mul  x17, x15, x3
02478933 00000320 // mul  x18, x15, x4
025789B3 000001F4 // mul  x19, x15, x5
02878A33 00000064 // mul  x20, x15, x8
02278AB3 FFFFFED4 // mul  x21, x15, x2
02F78B33 00002710 // mul  x22, x15, x15
02E78BB3 000001F4 // mul  x23, x15, x14
02078C33 00000000 // mul  x24, x15, x0

//--- ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  ooo_pkg::rv_inst_u inst_word,
    output logic              inst_ready,
    output ooo_pkg::cdb_t     cdb
);
    import ooo_pkg::*;

    rs_entry_t disp_entry;
    logic      rs_full;
    logic      issue_valid;
    exec_req_t issue_req;

    // Decode and rename
    dispatch_stage u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_ready (inst_ready),
        .rs_full    (rs_full),
        .cdb        (cdb),
        .disp_entry (disp_entry)
    );

    reservation_station u_rs (
        .clk         (clk),
        .rst         (rst),
        .disp_entry  (disp_entry),
        .cdb         (cdb),
        .rs_full     (rs_full),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    // Drives the CDB seen by everyone above
    execute_stage u_exec (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .cdb         (cdb)
    );

endmodule

//--- ooo_pkg.sv
package ooo_pkg;

    // Datapath and machine sizes
    localparam int XLEN          = 32;
    localparam int NUM_ARCH_REGS = 32;
    localparam int REG_W         = 5;
    localparam int TAG_W         = 4;
    localparam int RS_DEPTH      = 8;
    localparam int RS_IDX_W      = $clog2(RS_DEPTH);
    localparam int RS_CNT_W      = $clog2(RS_DEPTH) + 1;
    localparam int AGE_W         = 4;
    localparam int MUL_LATENCY   = 3;

    // RV32I encodings used by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL, OP_ADDI
    } op_t;

    // Same 32-bit word seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0]       funct7;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } r_view;
        struct packed {
            logic [11:0]      imm12;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } i_view;
    } rv_inst_u;

    // Source operand, value is meaningful only once ready
    typedef struct packed {
        logic [XLEN-1:0]  value;
        logic [TAG_W-1:0] tag;
        logic             ready;
    } operand_t;

    typedef struct packed {
        op_t              op;
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        operand_t         src1;
        operand_t         src2;
        logic             valid;
    } rs_entry_t;

    typedef struct packed {
        op_t              op;
        logic [TAG_W-1:0] tag;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  opa;
        logic [XLEN-1:0]  opb;
    } exec_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  value;
    } cdb_t;

    // Capture a broadcast result into a waiting operand
    function automatic operand_t wake_operand(operand_t op, cdb_t bus);
        operand_t res;
        res = op;
        if (!op.ready && bus.valid && (bus.tag == op.tag)) begin
            res.value = bus.value;
            res.ready = 1'b1;
        end
        return res;
    endfunction

endpackage

//--- rename_table.sv
`timescale 1ns/1ps

module rename_table (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [ooo_pkg::REG_W-1:0]  rs1_addr,
    input  logic [ooo_pkg::REG_W-1:0]  rs2_addr,
    output ooo_pkg::operand_t          rs1_op,
    output ooo_pkg::operand_t          rs2_op,
    input  logic                       alloc_en,
    input  logic [ooo_pkg::REG_W-1:0]  alloc_rd,
    input  logic [ooo_pkg::TAG_W-1:0]  alloc_tag,
    input  ooo_pkg::cdb_t              cdb
);
    import ooo_pkg::*;

    // Architectural values plus the tag of the youngest producer
    logic [XLEN-1:0]          reg_val [NUM_ARCH_REGS];
    logic [TAG_W-1:0]         reg_tag [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] pending;

    // One read port, x0 is hardwired ready zero
    function automatic operand_t read_reg(logic [REG_W-1:0] addr);
        operand_t res;
        if (addr == '0) begin
            res = '{value: '0, tag: '0, ready: 1'b1};
        end else if (pending[addr]) begin
            // Producer may be broadcasting right now
            res = wake_operand('{value: '0, tag: reg_tag[addr], ready: 1'b0}, cdb);
        end else begin
            res = '{value: reg_val[addr], tag: '0, ready: 1'b1};
        end
        return res;
    endfunction

    // Both ports follow the map and the CDB as well as the address
    always_comb begin
        rs1_op = read_reg(rs1_addr);
        rs2_op = read_reg(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            // Architectural state starts at zero
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                reg_val[i] <= '0;
            end
        end else begin
            for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                // Retire only if this register still waits on that tag
                if (cdb.valid && pending[i] && (reg_tag[i] == cdb.tag)) begin
                    reg_val[i] <= cdb.value;
                    pending[i] <= 1'b0;
                end
                // A new producer overrides the retirement
                if (alloc_en && (alloc_rd == REG_W'(i))) begin
                    pending[i] <= 1'b1;
                    reg_tag[i] <= alloc_tag;
                end
            end
        end
    end

endmodule

//--- reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::rs_entry_t disp_entry,
    input  ooo_pkg::cdb_t      cdb,
    output logic               rs_full,
    output logic               issue_valid,
    output ooo_pkg::exec_req_t issue_req
);
    import ooo_pkg::*;

    rs_entry_t            slots [RS_DEPTH];
    logic [AGE_W-1:0]     age [RS_DEPTH];
    // Bit k set when a MUL was issued k+1 cycles ago
    logic [MUL_LATENCY-1:0] mul_res;
    logic [RS_CNT_W-1:0]  count;
    logic [RS_IDX_W-1:0]  free_idx;
    logic [RS_IDX_W-1:0]  sel_idx;
    logic [AGE_W-1:0]     best_age;
    logic                 alu_block;
    logic                 eligible;

    // Occupancy and lowest free slot
    always_comb begin
        count    = '0;
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (slots[i].valid) begin
                count = count + 1'b1;
            end else begin
                free_idx = RS_IDX_W'(i);
            end
        end
    end

    // Full also counts the entry already sitting in dispatch
    assign rs_full = (count == RS_CNT_W'(RS_DEPTH))
                   || ((count == RS_CNT_W'(RS_DEPTH - 1)) && disp_entry.valid);

    // ALU result would land on the CDB together with a MUL result
    assign alu_block = mul_res[MUL_LATENCY-2];

    // Oldest entry with both operands ready
    always_comb begin
        issue_valid = 1'b0;
        sel_idx     = '0;
        best_age    = '0;
        eligible    = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            eligible = slots[i].valid && slots[i].src1.ready && slots[i].src2.ready
                       && ((slots[i].op == OP_MUL) || !alu_block);
            if (eligible && (!issue_valid || (age[i] > best_age))) begin
                issue_valid = 1'b1;
                sel_idx     = RS_IDX_W'(i);
                best_age    = age[i];
            end
        end
        issue_req = '{op:  slots[sel_idx].op,
                      tag: slots[sel_idx].tag,
                      rd:  slots[sel_idx].rd,
                      opa: slots[sel_idx].src1.value,
                      opb: slots[sel_idx].src2.value};
    end

    always_ff @(posedge clk) begin
        // CDB wakeup for every slot
        for (int i = 0; i < RS_DEPTH; i++) begin
            slots[i].src1 <= wake_operand(slots[i].src1, cdb);
            slots[i].src2 <= wake_operand(slots[i].src2, cdb);
        end
        // Arrival goes to the lowest free slot, older entries age
        if (disp_entry.valid) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (free_idx == RS_IDX_W'(i)) begin
                    slots[i] <= disp_entry;
                    age[i]   <= '0;
                end else if (age[i] != '1) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
        if (rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
            mul_res <= '0;
        end else begin
            if (issue_valid) begin
                slots[sel_idx].valid <= 1'b0;
            end
            mul_res <= {mul_res[MUL_LATENCY-2:0], issue_valid && (issue_req.op == OP_MUL)};
        end
    end

    // An empty table with nothing arriving has nothing to issue next cycle
    assert property (@(posedge clk) disable iff (rst)
        ((count == '0) && !disp_entry.valid) |=> !issue_valid)
        else $error("reservation_station: issue from an empty table");

    // An arrival always finds a free slot
    assert property (@(posedge clk) disable iff (rst)
        disp_entry.valid |-> (count != RS_CNT_W'(RS_DEPTH)))
        else $error("reservation_station: entry written while full");

    // Every claimed multiplier slot shows up on the CDB
    assert property (@(posedge clk) disable iff (rst) mul_res[MUL_LATENCY-1] |-> cdb.valid)
        else $error("reservation_station: MUL result missing from CDB");

endmodule

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int MAX_INSTS    = 64;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 10;

    logic              clk;
    logic              rst;
    logic              inst_valid;
    rv_inst_u          inst_word;
    logic              inst_ready;
    cdb_t              cdb;

    // Expectation port into the checker
    logic              exp_valid;
    logic [TAG_W-1:0]  exp_tag;
    logic [XLEN-1:0]   exp_value;
    logic [REG_W-1:0]  exp_rd;
    int                exp_name;
    int                mismatch_count;
    int                missing_count;
    int                unexpected_count;
    int                outstanding;

    // Instruction word and expected value alternate
    logic [XLEN-1:0]   stim_mem [2*MAX_INSTS];
    int                num_insts;
    int                stall_cycles;
    int                other_errors;
    bit                loaded;

    ooo_core_top uut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_ready (inst_ready),
        .cdb        (cdb)
    );

    ooo_core_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .cdb              (cdb),
        .exp_valid        (exp_valid),
        .exp_tag          (exp_tag),
        .exp_value        (exp_value),
        .exp_rd           (exp_rd),
        .exp_name         (exp_name),
        .mismatch_count   (mismatch_count),
        .missing_count    (missing_count),
        .unexpected_count (unexpected_count),
        .outstanding      (outstanding)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Zero word ends the program
    task automatic load_stimulus();
        for (int i = 0; i < 2 * MAX_INSTS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("ooo_core_stimulus.txt", stim_mem);
        num_insts = 0;
        while ((num_insts < MAX_INSTS) && (stim_mem[2*num_insts] != '0)) begin
            num_insts++;
        end
        if (num_insts == 0) begin
            other_errors++;
            $display("No instructions found in the stimulus file");
        end
    endtask

    // True for an R-type MUL encoding
    function automatic bit is_mul_word(input logic [XLEN-1:0] word);
        return (word[6:0] == OPC_OP) && (word[31:25] == F7_MULDIV);
    endfunction

    // Present one instruction on a falling edge and hold it until accepted
    task automatic send_inst(input int idx);
        logic accepted;
        inst_word  = stim_mem[2*idx];
        inst_valid = 1'b1;
        exp_valid  = 1'b1;
        exp_tag    = TAG_W'(idx);
        exp_rd     = stim_mem[2*idx][11:7];
        exp_value  = stim_mem[2*idx+1];
        exp_name   = idx;
        accepted   = 1'b0;
        while (!accepted) begin
            // inst_ready settles after the rising edge, safe to sample here
            accepted = inst_ready;
            if (!accepted) begin
                stall_cycles++;
            end
            @(posedge clk);
            @(negedge clk);
            exp_valid = 1'b0;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(negedge clk);
        end
        // Extra cycles expose duplicate results
        repeat (DRAIN_CYCLES) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("Closing counts: mismatch=%0d missing=%0d unexpected=%0d other=%0d",
                 mismatch_count, missing_count + outstanding, unexpected_count,
                 other_errors);
    endtask

    initial begin
        int          gap;
        int          total;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst_word    = '0;
        exp_valid    = 1'b0;
        exp_tag      = '0;
        exp_value    = '0;
        exp_rd       = '0;
        exp_name     = 0;
        stall_cycles = 0;
        other_errors = 0;
        void'($urandom(32'he32e));
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_insts; i++) begin
            // Random bubbles between instructions
            gap = $urandom % 3;
            // MULs go back to back so the burst can fill the station
            if (is_mul_word(stim_mem[2*i])) begin
                gap = 0;
            end
            repeat (gap) @(negedge clk);
            send_inst(i);
        end
        wait_drain();
        $display("Sent %0d instructions, station back-pressure for %0d cycles",
                 num_insts, stall_cycles);
        if (stall_cycles == 0) begin
            other_errors++;
            $display("The station never pulled inst_ready low during the MUL burst");
        end
        print_counts();
        total = mismatch_count + missing_count + outstanding + unexpected_count
              + other_errors;
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + num_insts * 20 + 200) @(posedge clk);
        $display("Run timed out with %0d results still outstanding", outstanding);
        print_counts();
        $display("Regression failed");
        $finish;
    end

endmodule
